// ==== l1d_pipe.f ====
+incdir+dv
design/l1d_pkg.sv
design/dpsram.sv
design/store_buffer.sv
design/load_align.sv
design/dcache.sv
design/commit_writer.sv
design/l1d_top.sv
dv/l1d_tb.sv

// ==== Bender.yml ====
package:
  name: l1d_pipe

sources:
  - files:
      - design/l1d_pkg.sv
      - design/dpsram.sv
      - design/store_buffer.sv
      - design/load_align.sv
      - design/dcache.sv
      - design/commit_writer.sv
      - design/l1d_top.sv
  - target: simulation
    include_dirs:
      - dv
    files:
      - dv/l1d_tb.sv

// ==== dv/l1d_model.svh ====
`ifndef L1D_MODEL_SVH
`define L1D_MODEL_SVH

typedef struct {
    logic [29:0] waddr;
    logic [31:0] data;
    logic [3:0] strb;
    logic unc;
    logic [1:0] hit;
} mstore_t;

// arrays as port 0 sees them after each clock edge
logic [18:0] m_tag [64][2];
logic m_valid [64][2];
logic [31:0] m_data [256][2];
logic m_ptr;
logic m_pend;
mstore_t m_q [$];

// data row is line index with the word in line
function automatic int row_of(input logic [31:0] a);
    return {a[11:6], a[3:2]};
endfunction

task automatic model_reset();
    for (int i = 0; i < 64; i++) begin
        m_valid[i][0] = 1'b0;
        m_valid[i][1] = 1'b0;
    end
    m_ptr = 1'b0;
    m_pend = 1'b0;
    m_q.delete();
endtask

task automatic model_refill(input logic [31:0] a, input logic [31:0] d);
    m_tag[a[11:6]][m_ptr] = a[30:12];
    m_valid[a[11:6]][m_ptr] = 1'b1;
    m_data[row_of(a)][m_ptr] = d;
    m_ptr = ~m_ptr;
endtask

// oldest store leaves, hit ways take its bytes
task automatic model_commit(output mstore_t e);
    int r;
    e = m_q.pop_front();
    r = row_of({e.waddr, 2'b00});
    for (int w = 0; w < 2; w++) begin
        for (int l = 0; l < 4; l++) begin
            if (e.hit[w] && e.strb[l]) begin
                m_data[r][w][8*l +: 8] = e.data[8*l +: 8];
            end
        end
    end
endtask

function automatic logic [31:0] extend_load(input logic [31:0] wd, input logic [3:0] mask,
                                            input logic [1:0] sz, input logic sgn);
    logic [7:0] b;
    logic [15:0] h;
    b = wd[7:0];
    for (int l = 0; l < 4; l++) begin
        if (mask == (4'b1 << l)) begin
            b = wd[8*l +: 8];
        end
    end
    h = (mask == 4'hc) ? wd[31:16] : wd[15:0];
    if (sz == 2'd0) begin
        return {{24{sgn & b[7]}}, b};
    end else if (sz == 2'd1) begin
        return {{16{sgn & h[15]}}, h};
    end
    return wd;
endfunction

task automatic model_lookup(input logic [31:0] a, input logic [3:0] mask, input logic [1:0] sz,
                            input logic sgn, output logic hit, output logic [1:0] th,
                            output logic [31:0] rd);
    logic [31:0] hw;
    logic [31:0] fd;
    logic [3:0] fh;
    hw = '0;
    fd = '0;
    fh = '0;
    for (int w = 0; w < 2; w++) begin
        th[w] = !a[31] && m_valid[a[11:6]][w] && (m_tag[a[11:6]][w] == a[30:12]);
        if (th[w]) begin
            hw |= m_data[row_of(a)][w];
        end
    end
    // younger entries come later and overwrite
    foreach (m_q[i]) begin
        for (int l = 0; l < 4; l++) begin
            if (m_q[i].waddr == a[31:2] && m_q[i].strb[l]) begin
                fh[l] = 1'b1;
                fd[8*l +: 8] = m_q[i].data[8*l +: 8];
            end
        end
    end
    for (int l = 0; l < 4; l++) begin
        if (fh[l]) begin
            hw[8*l +: 8] = fd[8*l +: 8];
        end
    end
    hit = !a[31] && ((|th) || (mask != 4'h0 && (mask & fh) == mask));
    rd = extend_load(hw, mask, sz, sgn);
endtask

`endif

// ==== dv/l1d_tb.sv ====
`timescale 1ns/100ps

module l1d_tb;
    import l1d_pkg::*;

    localparam int unsigned SB_SIZE = 4;
    localparam int unsigned TOTAL_CYCLES = 8 + 12 + 72 + 60 + 60 + 70 + 43;

    logic clk;
    logic rst_n;
    logic req_valid_i, req_store_i, req_signed_i, req_ready_o;
    logic [31:0] req_addr_i, req_wdata_i;
    logic [3:0] req_wstrb_i, req_rmask_i, req_id_i;
    msize_e req_size_i;
    logic rsp_valid_o, rsp_hit_o, rsp_uncached_o;
    logic [3:0] rsp_id_o;
    logic [31:0] rsp_rdata_o;
    logic refill_valid_i, commit_i;
    logic [31:0] refill_addr_i, refill_data_i;
    logic drain_valid_o, drain_uncached_o;
    logic [31:0] drain_addr_o, drain_data_o;
    logic [3:0] drain_strb_o;

    logic [31:0] lfsr;
    int errors, checks, test_start;
    int stores_in, drains_out;
    logic exp_rsp_valid, exp_hit, exp_unc, exp_drain_valid, m1_store_pend;
    logic [3:0] exp_id;
    logic [31:0] exp_rdata;
    logic [1:0] exp_th;
    logic [3:0] next_id;

    `include "l1d_model.svh"

    mstore_t exp_drain, m1_entry;

    l1d_top #(.SETS(64), .WORDS_PER_LINE(4), .SB_SIZE(SB_SIZE)) l1d_top_i (.*);

    always #10 clk = ~clk;

    // 32-bit Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic logic [31:0] pool_addr(input logic allow_unc);
        logic [31:0] a;
        a = '0;
        a[31] = allow_unc && (rand_bits(3) == 0);
        a[30:12] = 1 + (rand_bits(2) % 3);
        a[11] = rand_bits(1);
        a[6] = rand_bits(1);
        a[3:2] = rand_bits(2);
        return a;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("[FAIL] %s exp %h got %h", name, exp, got);
            errors++;
        end
    endtask

    task automatic check_outputs();
        check_val("req_ready_o", req_ready_o, m_q.size() < SB_SIZE - 1);
        check_val("rsp_valid_o", rsp_valid_o, exp_rsp_valid);
        if (exp_rsp_valid) begin
            check_val("rsp_id_o", rsp_id_o, exp_id);
            check_val("rsp_hit_o", rsp_hit_o, exp_hit);
            check_val("rsp_uncached_o", rsp_uncached_o, exp_unc);
            check_val("rsp_rdata_o", rsp_rdata_o, exp_rdata);
        end
        check_val("drain_valid_o", drain_valid_o, exp_drain_valid);
        if (drain_valid_o === 1'b1) begin
            drains_out++;
        end
        if (exp_drain_valid) begin
            check_val("drain_addr_o", drain_addr_o, {exp_drain.waddr, 2'b00});
            check_val("drain_data_o", drain_data_o, exp_drain.data);
            check_val("drain_strb_o", drain_strb_o, exp_drain.strb);
            check_val("drain_uncached_o", drain_uncached_o, exp_drain.unc);
        end
    endtask

    // effects of the coming edge in the order the hardware applies them
    task automatic model_edge();
        logic do_commit;
        logic ready;
        ready = m_q.size() < SB_SIZE - 1;
        do_commit = !refill_valid_i && (commit_i || m_pend);
        exp_drain_valid = do_commit;
        if (do_commit) begin
            model_commit(exp_drain);
        end
        if (commit_i && (refill_valid_i || m_pend)) begin
            m_pend = 1'b1;
        end else if (do_commit) begin
            m_pend = 1'b0;
        end
        if (refill_valid_i) begin
            model_refill(refill_addr_i, refill_data_i);
        end
        if (m1_store_pend) begin
            m_q.push_back(m1_entry);
            m1_store_pend = 1'b0;
        end
        exp_rsp_valid = req_valid_i && ready;
        if (exp_rsp_valid) begin
            model_lookup(req_addr_i, req_rmask_i, req_size_i, req_signed_i,
                         exp_hit, exp_th, exp_rdata);
            exp_id = req_id_i;
            exp_unc = req_addr_i[31];
            if (req_store_i) begin
                m1_entry = '{req_addr_i[31:2], req_wdata_i, req_wstrb_i, req_addr_i[31], exp_th};
                m1_store_pend = 1'b1;
                stores_in++;
            end
        end
    endtask

    task automatic gen_cycle(input int p_st, input int p_ld, input int p_rf, input int p_cm,
                             input logic bypass);
        int r;
        int sz;
        logic [3:0] mask;
        logic [31:0] a;
        logic v, st, rf, cm;
        v = 1'b0;
        st = 1'b0;
        rf = rand_bits(4) < p_rf;
        cm = m_q.size() > 0 && !m_pend && rand_bits(4) < p_cm;
        a = pool_addr(1'b1);
        sz = 2;
        mask = 4'h0;
        r = rand_bits(4);
        if (r < p_st + p_ld) begin
            v = 1'b1;
            st = r < p_st;
            sz = st ? 2 : rand_bits(2);
            if (!st) begin
                if (sz == 0) begin
                    mask = 4'b1 << rand_bits(2);
                end else if (sz == 1) begin
                    mask = rand_bits(1) ? 4'hc : 4'h3;
                end else begin
                    mask = 4'hf;
                end
                sz = (sz > 2) ? 2 : sz;
            end
        end
        // load the word that is being written back this cycle
        if (bypass && cm && !rf && m_q[0].hit != 2'b00) begin
            v = 1'b1;
            st = 1'b0;
            a = {m_q[0].waddr, 2'b00};
            sz = 2;
            mask = 4'hf;
        end
        @(posedge clk);
        req_valid_i <= v;
        req_store_i <= st;
        req_addr_i <= a;
        req_wdata_i <= rand_bits(32);
        req_wstrb_i <= rand_bits(4);
        req_rmask_i <= mask;
        req_size_i <= msize_e'(sz);
        req_signed_i <= rand_bits(1);
        req_id_i <= next_id;
        refill_valid_i <= rf;
        refill_addr_i <= pool_addr(1'b0);
        refill_data_i <= rand_bits(32);
        commit_i <= cm;
        next_id = next_id + 1'b1;
        @(negedge clk);
        check_outputs();
        model_edge();
    endtask

    task automatic refill_word(input logic [31:0] a);
        @(posedge clk);
        req_valid_i <= 1'b0;
        commit_i <= 1'b0;
        refill_valid_i <= 1'b1;
        refill_addr_i <= a;
        refill_data_i <= rand_bits(32);
        @(negedge clk);
        check_outputs();
        model_edge();
    endtask

    task automatic end_test(input string name);
        $display("test %s finished with %0d errors", name, errors - test_start);
        test_start = errors;
    endtask

    initial begin
        #(TOTAL_CYCLES * 40);
        $display("watchdog expired before the tests completed");
        $display("Done: errors found");
        $finish;
    end

    initial begin
        logic saw_full;
        clk = 1'b0;
        rst_n = 1'b0;
        lfsr = 32'h3594638b;
        {req_valid_i, req_store_i, req_signed_i, refill_valid_i, commit_i} = '0;
        {req_addr_i, req_wdata_i, refill_addr_i, refill_data_i} = '0;
        {req_wstrb_i, req_rmask_i, req_id_i} = '0;
        req_size_i = MSIZE_W;
        {errors, checks, test_start} = '0;
        {stores_in, drains_out} = '0;
        {exp_rsp_valid, exp_drain_valid, m1_store_pend} = '0;
        next_id = '0;
        saw_full = 1'b0;
        model_reset();
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;

        repeat (12) gen_cycle(0, 12, 0, 0, 1'b0);
        end_test("reset_state");

        // every pool row of both ways gets defined data first
        for (int i = 0; i < 4; i++) begin
            for (int w = 0; w < 4; w++) begin
                refill_word(32'h1000 | ((i >> 1) << 11) | ((i & 1) << 6) | (w << 2));
                refill_word(32'h2000 | ((i >> 1) << 11) | ((i & 1) << 6) | (w << 2));
            end
        end
        repeat (40) gen_cycle(0, 10, 4, 0, 1'b0);
        end_test("refill_load");

        repeat (60) gen_cycle(6, 8, 1, 3, 1'b0);
        end_test("store_forward");

        repeat (60) gen_cycle(5, 6, 0, 8, 1'b1);
        end_test("commit_drain");

        repeat (30) begin
            gen_cycle(14, 0, 0, 0, 1'b0);
            if (!req_ready_o) begin
                saw_full = 1'b1;
            end
        end
        if (!saw_full) begin
            $display("req_ready_o never dropped while stores filled the buffer");
            errors++;
        end
        repeat (40) gen_cycle(4, 2, 8, 6, 1'b0);
        for (int n = 0; n < 40 && (m_q.size() > 0 || m_pend || m1_store_pend); n++) begin
            gen_cycle(0, 0, 0, 16, 1'b0);
        end
        repeat (3) gen_cycle(0, 0, 0, 0, 1'b0);
        if (drains_out != stores_in) begin
            $display("%0d stores were accepted but %0d drains came out", stores_in, drains_out);
            errors++;
        end
        end_test("full_arbitration");

        $display("5 tests, %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== design/l1d_top.sv ====
`timescale 1ns/100ps

module l1d_top #(
    parameter int unsigned SETS = 64,
    parameter int unsigned WORDS_PER_LINE = 4,
    parameter int unsigned SB_SIZE = 4
) (
    input  logic clk,
    input  logic rst_n,
    input  logic req_valid_i,
    input  logic [l1d_pkg::ADDR_W-1:0] req_addr_i,
    input  logic req_store_i,
    input  logic [l1d_pkg::WORD_W-1:0] req_wdata_i,
    input  logic [l1d_pkg::STRB_W-1:0] req_wstrb_i,
    input  logic [l1d_pkg::STRB_W-1:0] req_rmask_i,
    input  l1d_pkg::msize_e req_size_i,
    input  logic req_signed_i,
    input  logic [l1d_pkg::ID_W-1:0] req_id_i,
    output logic req_ready_o,
    output logic rsp_valid_o,
    output logic [l1d_pkg::ID_W-1:0] rsp_id_o,
    output logic rsp_hit_o,
    output logic rsp_uncached_o,
    output logic [l1d_pkg::WORD_W-1:0] rsp_rdata_o,
    input  logic refill_valid_i,
    input  logic [l1d_pkg::ADDR_W-1:0] refill_addr_i,
    input  logic [l1d_pkg::WORD_W-1:0] refill_data_i,
    input  logic commit_i,
    output logic drain_valid_o,
    output logic [l1d_pkg::ADDR_W-1:0] drain_addr_o,
    output logic [l1d_pkg::WORD_W-1:0] drain_data_o,
    output logic [l1d_pkg::STRB_W-1:0] drain_strb_o,
    output logic drain_uncached_o
);
    import l1d_pkg::*;

    logic wr_en;
    logic [ADDR_W-1:0] wr_addr;
    logic [WAY_NUM-1:0] wr_way;
    line_tag_t wr_tag;
    logic wr_tag_we;
    logic [WORD_W-1:0] wr_data;
    logic [STRB_W-1:0] wr_strb;
    logic sb_pop;
    sb_entry_t sb_head;
    logic sb_empty;
    logic refill_way;

    dcache #(
        .SETS(SETS),
        .WORDS_PER_LINE(WORDS_PER_LINE),
        .SB_SIZE(SB_SIZE)
    ) dcache_i (
        .clk,
        .rst_n,
        .req_valid_i,
        .req_addr_i,
        .req_store_i,
        .req_wdata_i,
        .req_wstrb_i,
        .req_rmask_i,
        .req_size_i,
        .req_signed_i,
        .req_id_i,
        .req_ready_o,
        .rsp_valid_o,
        .rsp_id_o,
        .rsp_hit_o,
        .rsp_uncached_o,
        .rsp_rdata_o,
        .wr_en_i(wr_en),
        .wr_addr_i(wr_addr),
        .wr_way_i(wr_way),
        .wr_tag_i(wr_tag),
        .wr_tag_we_i(wr_tag_we),
        .wr_data_i(wr_data),
        .wr_strb_i(wr_strb),
        .sb_pop_i(sb_pop),
        .sb_head_o(sb_head),
        .sb_empty_o(sb_empty),
        .refill_way_o(refill_way)
    );

    commit_writer commit_writer_i (
        .clk,
        .rst_n,
        .refill_valid_i,
        .refill_addr_i,
        .refill_data_i,
        .refill_way_i(refill_way),
        .commit_i,
        .sb_head_i(sb_head),
        .sb_empty_i(sb_empty),
        .wr_en_o(wr_en),
        .wr_addr_o(wr_addr),
        .wr_way_o(wr_way),
        .wr_tag_o(wr_tag),
        .wr_tag_we_o(wr_tag_we),
        .wr_data_o(wr_data),
        .wr_strb_o(wr_strb),
        .sb_pop_o(sb_pop),
        .drain_valid_o,
        .drain_addr_o,
        .drain_data_o,
        .drain_strb_o,
        .drain_uncached_o
    );

endmodule

// ==== design/commit_writer.sv ====
`timescale 1ns/100ps

module commit_writer (
    input  logic clk,
    input  logic rst_n,
    input  logic refill_valid_i,
    input  logic [l1d_pkg::ADDR_W-1:0] refill_addr_i,
    input  logic [l1d_pkg::WORD_W-1:0] refill_data_i,
    input  logic refill_way_i,
    input  logic commit_i,
    input  l1d_pkg::sb_entry_t sb_head_i,
    input  logic sb_empty_i,
    output logic wr_en_o,
    output logic [l1d_pkg::ADDR_W-1:0] wr_addr_o,
    output logic [l1d_pkg::WAY_NUM-1:0] wr_way_o,
    output l1d_pkg::line_tag_t wr_tag_o,
    output logic wr_tag_we_o,
    output logic [l1d_pkg::WORD_W-1:0] wr_data_o,
    output logic [l1d_pkg::STRB_W-1:0] wr_strb_o,
    output logic sb_pop_o,
    output logic drain_valid_o,
    output logic [l1d_pkg::ADDR_W-1:0] drain_addr_o,
    output logic [l1d_pkg::WORD_W-1:0] drain_data_o,
    output logic [l1d_pkg::STRB_W-1:0] drain_strb_o,
    output logic drain_uncached_o
);
    import l1d_pkg::*;

    logic pending_q;
    logic do_commit;

    // refill owns port 1, commits wait for a free cycle
    assign do_commit = ~refill_valid_i & (commit_i | pending_q);
    assign sb_pop_o = do_commit;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pending_q <= 1'b0;
        end else if (commit_i && (refill_valid_i || pending_q)) begin
            pending_q <= 1'b1;
        end else if (do_commit) begin
            pending_q <= 1'b0;
        end
    end

    always_comb begin
        if (refill_valid_i) begin
            wr_en_o = 1'b1;
            wr_addr_o = refill_addr_i;
            wr_way_o = WAY_NUM'(1) << refill_way_i;
            wr_tag_we_o = 1'b1;
            wr_data_o = refill_data_i;
            wr_strb_o = '1;
        end else begin
            // only stores that hit update the array
            wr_en_o = do_commit & (|sb_head_i.hit);
            wr_addr_o = {sb_head_i.waddr, {OFFS_LSB{1'b0}}};
            wr_way_o = sb_head_i.hit;
            wr_tag_we_o = 1'b0;
            wr_data_o = sb_head_i.data;
            wr_strb_o = sb_head_i.strb;
        end
    end

    assign wr_tag_o = refill_addr_i[TAG_LSB +: TAG_W];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            drain_valid_o <= 1'b0;
        end else begin
            drain_valid_o <= do_commit;
        end
    end

    always_ff @(posedge clk) begin
        if (do_commit) begin
            drain_addr_o <= {sb_head_i.waddr, {OFFS_LSB{1'b0}}};
            drain_data_o <= sb_head_i.data;
            drain_strb_o <= sb_head_i.strb;
            drain_uncached_o <= sb_head_i.uncached;
        end
    end

    a_commit_not_empty: assert property (@(posedge clk) disable iff (!rst_n)
        commit_i |-> !sb_empty_i);

    // a second blocked commit would have nowhere to wait
    a_commit_not_lost: assert property (@(posedge clk) disable iff (!rst_n)
        commit_i && refill_valid_i |-> !pending_q);

endmodule

// ==== design/dcache.sv ====
`timescale 1ns/100ps

module dcache #(
    parameter int unsigned SETS = 64,
    parameter int unsigned WORDS_PER_LINE = 4,
    parameter int unsigned SB_SIZE = 4
) (
    input  logic clk,
    input  logic rst_n,
    // request in M0
    input  logic req_valid_i,
    input  logic [l1d_pkg::ADDR_W-1:0] req_addr_i,
    input  logic req_store_i,
    input  logic [l1d_pkg::WORD_W-1:0] req_wdata_i,
    input  logic [l1d_pkg::STRB_W-1:0] req_wstrb_i,
    input  logic [l1d_pkg::STRB_W-1:0] req_rmask_i,
    input  l1d_pkg::msize_e req_size_i,
    input  logic req_signed_i,
    input  logic [l1d_pkg::ID_W-1:0] req_id_i,
    output logic req_ready_o,
    // response in M1
    output logic rsp_valid_o,
    output logic [l1d_pkg::ID_W-1:0] rsp_id_o,
    output logic rsp_hit_o,
    output logic rsp_uncached_o,
    output logic [l1d_pkg::WORD_W-1:0] rsp_rdata_o,
    // array writes on port 1
    input  logic wr_en_i,
    input  logic [l1d_pkg::ADDR_W-1:0] wr_addr_i,
    input  logic [l1d_pkg::WAY_NUM-1:0] wr_way_i,
    input  l1d_pkg::line_tag_t wr_tag_i,
    input  logic wr_tag_we_i,
    input  logic [l1d_pkg::WORD_W-1:0] wr_data_i,
    input  logic [l1d_pkg::STRB_W-1:0] wr_strb_i,
    // store buffer head and refill pointer
    input  logic sb_pop_i,
    output l1d_pkg::sb_entry_t sb_head_o,
    output logic sb_empty_o,
    output logic refill_way_o
);
    import l1d_pkg::*;

    localparam int unsigned IDX_W = $clog2(SETS);
    localparam int unsigned WOFF_W = $clog2(WORDS_PER_LINE);
    localparam int unsigned ROW_W = IDX_W + WOFF_W;
    localparam int unsigned IDX_LSB = TAG_LSB - IDX_W;

    logic req_fire;
    logic m1_valid_q;
    logic [ADDR_W-1:0] m1_addr_q;
    logic m1_store_q;
    logic [WORD_W-1:0] m1_wdata_q;
    logic [STRB_W-1:0] m1_wstrb_q;
    logic [STRB_W-1:0] m1_rmask_q;
    msize_e m1_size_q;
    logic m1_signed_q;
    logic [ID_W-1:0] m1_id_q;
    logic m1_uncached;
    logic [ROW_W-1:0] req_row;
    logic [ROW_W-1:0] wr_row;

    logic [WAY_NUM-1:0] tag_hit;
    logic [WAY_NUM-1:0][WORD_W-1:0] way_word;
    logic [WORD_W-1:0] hit_word;
    logic [WORD_W-1:0] merged;
    logic [STRB_W-1:0] fwd_hit;
    logic [WORD_W-1:0] fwd_data;
    logic full_fwd;
    logic sb_almost_full;
    sb_entry_t sb_entry;
    logic refill_ptr_q;

    assign req_ready_o = ~sb_almost_full;
    assign req_fire = req_valid_i & req_ready_o;

    // data row is the line index followed by the word in the line
    assign req_row = {req_addr_i[IDX_LSB +: IDX_W], req_addr_i[OFFS_LSB +: WOFF_W]};
    assign wr_row = {wr_addr_i[IDX_LSB +: IDX_W], wr_addr_i[OFFS_LSB +: WOFF_W]};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            m1_valid_q <= 1'b0;
        end else begin
            m1_valid_q <= req_fire;
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire) begin
            m1_addr_q <= req_addr_i;
            m1_store_q <= req_store_i;
            m1_wdata_q <= req_wdata_i;
            m1_wstrb_q <= req_wstrb_i;
            m1_rmask_q <= req_rmask_i;
            m1_size_q <= req_size_i;
            m1_signed_q <= req_signed_i;
            m1_id_q <= req_id_i;
        end
    end

    assign m1_uncached = m1_addr_q[ADDR_W-1];

    for (genvar w = 0; w < WAY_NUM; w++) begin : g_way
        logic tag_we;
        logic [STRB_W-1:0] data_we;
        logic tag_conf;
        logic tag_conf_q;
        logic data_conf;
        logic data_conf_q;
        line_tag_t rtag0;
        line_tag_t rtag1;
        line_tag_t tag_rd;
        logic [WORD_W-1:0] rdata0;
        logic [WORD_W-1:0] rdata1;
        logic [SETS-1:0] valid_q;

        assign tag_we = wr_en_i & wr_tag_we_i & wr_way_i[w];
        assign data_we = {STRB_W{wr_en_i & wr_way_i[w]}} & wr_strb_i;

        // read and write on the same row take port 1's fresh copy
        assign tag_conf = req_fire & tag_we
            & (req_addr_i[IDX_LSB +: IDX_W] == wr_addr_i[IDX_LSB +: IDX_W]);
        assign data_conf = req_fire & (|data_we) & (req_row == wr_row);

        always_ff @(posedge clk) begin
            if (!rst_n) begin
                tag_conf_q <= 1'b0;
                data_conf_q <= 1'b0;
                valid_q <= '0;
            end else begin
                tag_conf_q <= tag_conf;
                data_conf_q <= data_conf;
                if (tag_we) begin
                    valid_q[wr_addr_i[IDX_LSB +: IDX_W]] <= 1'b1;
                end
            end
        end

        dpsram #(
            .T(line_tag_t),
            .LANES(1),
            .DEPTH(SETS)
        ) tag_ram_i (
            .clk,
            .addr0_i(req_addr_i[IDX_LSB +: IDX_W]),
            .en0_i(req_fire),
            .rdata0_o(rtag0),
            .addr1_i(wr_addr_i[IDX_LSB +: IDX_W]),
            .we1_i(tag_we),
            .wdata1_i(wr_tag_i),
            .rdata1_o(rtag1)
        );

        dpsram #(
            .T(logic [WORD_W-1:0]),
            .LANES(STRB_W),
            .DEPTH(SETS * WORDS_PER_LINE)
        ) data_ram_i (
            .clk,
            .addr0_i(req_row),
            .en0_i(req_fire),
            .rdata0_o(rdata0),
            .addr1_i(wr_row),
            .we1_i(data_we),
            .wdata1_i(wr_data_i),
            .rdata1_o(rdata1)
        );

        assign tag_rd = tag_conf_q ? rtag1 : rtag0;
        assign tag_hit[w] = ~m1_uncached & valid_q[m1_addr_q[IDX_LSB +: IDX_W]]
            & (tag_rd == m1_addr_q[TAG_LSB +: TAG_W]);
        assign way_word[w] = tag_hit[w] ? (data_conf_q ? rdata1 : rdata0) : '0;
    end

    // pending store bytes sit over the array word
    always_comb begin
        hit_word = '0;
        for (int w = 0; w < WAY_NUM; w++) begin
            hit_word |= way_word[w];
        end
        for (int l = 0; l < STRB_W; l++) begin
            merged[8*l +: 8] = fwd_hit[l] ? fwd_data[8*l +: 8] : hit_word[8*l +: 8];
        end
    end

    assign full_fwd = (|m1_rmask_q) & ((m1_rmask_q & fwd_hit) == m1_rmask_q);

    assign rsp_valid_o = m1_valid_q;
    assign rsp_id_o = m1_id_q;
    assign rsp_uncached_o = m1_uncached;
    assign rsp_hit_o = ~m1_uncached & ((|tag_hit) | full_fwd);

    load_align load_align_i (
        .word_i(merged),
        .rmask_i(m1_rmask_q),
        .size_i(m1_size_q),
        .signed_i(m1_signed_q),
        .data_o(rsp_rdata_o)
    );

    assign sb_entry.waddr = m1_addr_q[ADDR_W-1:OFFS_LSB];
    assign sb_entry.data = m1_wdata_q;
    assign sb_entry.strb = m1_wstrb_q;
    assign sb_entry.uncached = m1_uncached;
    assign sb_entry.hit = tag_hit;

    store_buffer #(
        .SB_SIZE(SB_SIZE)
    ) store_buffer_i (
        .clk,
        .rst_n,
        .push_i(m1_valid_q & m1_store_q),
        .entry_i(sb_entry),
        .pop_i(sb_pop_i),
        .head_o(sb_head_o),
        .empty_o(sb_empty_o),
        .almost_full_o(sb_almost_full),
        .fwd_addr_i(m1_addr_q[ADDR_W-1:OFFS_LSB]),
        .fwd_hit_o(fwd_hit),
        .fwd_data_o(fwd_data)
    );

    // each tag write is one refill word and flips the pointer
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            refill_ptr_q <= 1'b0;
        end else if (wr_en_i && wr_tag_we_i) begin
            refill_ptr_q <= ~refill_ptr_q;
        end
    end

    assign refill_way_o = refill_ptr_q;

endmodule

// ==== design/load_align.sv ====
`timescale 1ns/100ps

module load_align (
    input  logic [l1d_pkg::WORD_W-1:0] word_i,
    input  logic [l1d_pkg::STRB_W-1:0] rmask_i,
    input  l1d_pkg::msize_e size_i,
    input  logic signed_i,
    output logic [l1d_pkg::WORD_W-1:0] data_o
);
    import l1d_pkg::*;

    logic [7:0] byte_sel;
    logic [15:0] half_sel;

    always_comb begin
        byte_sel = '0;
        for (int l = 0; l < STRB_W; l++) begin
            if (rmask_i[l]) begin
                byte_sel = word_i[8*l +: 8];
            end
        end
    end

    // upper half when the mask names lanes 2 and 3
    assign half_sel = rmask_i[2] ? word_i[31:16] : word_i[15:0];

    always_comb begin
        case (size_i)
            MSIZE_B: data_o = {{(WORD_W - 8){signed_i & byte_sel[7]}}, byte_sel};
            MSIZE_H: data_o = {{(WORD_W - 16){signed_i & half_sel[15]}}, half_sel};
            MSIZE_W: data_o = word_i;
            default: data_o = word_i;
        endcase
    end

endmodule

// ==== design/store_buffer.sv ====
`timescale 1ns/100ps

module store_buffer #(
    parameter int unsigned SB_SIZE = 4
) (
    input  logic clk,
    input  logic rst_n,
    input  logic push_i,
    input  l1d_pkg::sb_entry_t entry_i,
    input  logic pop_i,
    output l1d_pkg::sb_entry_t head_o,
    output logic empty_o,
    output logic almost_full_o,
    // forwarding search by word address
    input  logic [l1d_pkg::ADDR_W-l1d_pkg::OFFS_LSB-1:0] fwd_addr_i,
    output logic [l1d_pkg::STRB_W-1:0] fwd_hit_o,
    output logic [l1d_pkg::WORD_W-1:0] fwd_data_o
);
    import l1d_pkg::*;

    localparam int unsigned PTR_W = $clog2(SB_SIZE);

    sb_entry_t mem_q [SB_SIZE];
    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W:0] count_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop_i) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            count_q <= count_q + {{PTR_W{1'b0}}, push_i} - {{PTR_W{1'b0}}, pop_i};
        end
    end

    always_ff @(posedge clk) begin
        if (push_i) begin
            mem_q[wr_ptr_q] <= entry_i;
        end
    end

    assign head_o = mem_q[rd_ptr_q];
    assign empty_o = (count_q == '0);
    // one slot kept free for the store already in M1
    assign almost_full_o = (count_q >= (PTR_W + 1)'(SB_SIZE - 1));

    // oldest to youngest, so the youngest matching byte wins
    always_comb begin
        logic [PTR_W-1:0] slot;
        fwd_hit_o = '0;
        fwd_data_o = '0;
        for (int i = 0; i < SB_SIZE; i++) begin
            slot = rd_ptr_q + PTR_W'(i);
            if (i < count_q && mem_q[slot].waddr == fwd_addr_i) begin
                for (int l = 0; l < STRB_W; l++) begin
                    if (mem_q[slot].strb[l]) begin
                        fwd_hit_o[l] = 1'b1;
                        fwd_data_o[8*l +: 8] = mem_q[slot].data[8*l +: 8];
                    end
                end
            end
        end
    end

    // ready must have held back the request that would overflow
    a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
        push_i |-> count_q != (PTR_W + 1)'(SB_SIZE));

    a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
        pop_i |-> count_q != '0);

endmodule

// ==== design/dpsram.sv ====
`timescale 1ns/100ps

module dpsram #(
    parameter type T = logic [31:0],
    parameter int unsigned LANES = 4,
    parameter int unsigned DEPTH = 256
) (
    input  logic clk,
    // port 0, read only
    input  logic [$clog2(DEPTH)-1:0] addr0_i,
    input  logic en0_i,
    output T rdata0_o,
    // port 1, lane writes and write-first read
    input  logic [$clog2(DEPTH)-1:0] addr1_i,
    input  logic [LANES-1:0] we1_i,
    input  T wdata1_i,
    output T rdata1_o
);
    localparam int unsigned LANE_W = $bits(T) / LANES;

    typedef logic [LANES-1:0][LANE_W-1:0] row_t;

    row_t mem_q [DEPTH];
    row_t wrow;
    row_t nrow;
    row_t rdata0_q;
    row_t rdata1_q;

    assign wrow = row_t'(wdata1_i);

    // row as it looks after this cycle's write
    always_comb begin
        nrow = mem_q[addr1_i];
        for (int l = 0; l < LANES; l++) begin
            if (we1_i[l]) begin
                nrow[l] = wrow[l];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (en0_i) begin
            rdata0_q <= mem_q[addr0_i];
        end
    end

    always_ff @(posedge clk) begin
        for (int l = 0; l < LANES; l++) begin
            if (we1_i[l]) begin
                mem_q[addr1_i][l] <= wrow[l];
            end
        end
        rdata1_q <= nrow;
    end

    assign rdata0_o = T'(rdata0_q);
    assign rdata1_o = T'(rdata1_q);

endmodule

// ==== design/l1d_pkg.sv ====
package l1d_pkg;

    localparam int unsigned ADDR_W = 32;
    localparam int unsigned WORD_W = 32;
    localparam int unsigned STRB_W = WORD_W / 8;
    localparam int unsigned WAY_NUM = 2;
    localparam int unsigned OFFS_LSB = 2;
    localparam int unsigned ID_W = 4;

    // stored tag is address bits 30..12, bit 31 marks uncached
    localparam int unsigned TAG_LSB = 12;
    localparam int unsigned TAG_W = ADDR_W - 1 - TAG_LSB;

    typedef logic [TAG_W-1:0] line_tag_t;

    typedef enum logic [1:0] {
        MSIZE_B = 2'd0,
        MSIZE_H = 2'd1,
        MSIZE_W = 2'd2
    } msize_e;

    // one pending store, hit is one-hot over the ways
    typedef struct packed {
        logic [ADDR_W-OFFS_LSB-1:0] waddr;
        logic [WORD_W-1:0] data;
        logic [STRB_W-1:0] strb;
        logic uncached;
        logic [WAY_NUM-1:0] hit;
    } sb_entry_t;

endpackage
